//--- time_sync.f
rtl/time_sync_pkg.sv
rtl/code_word_if.sv
rtl/enc_8b10b.sv
rtl/dec_8b10b.sv
rtl/time_sender.sv
rtl/time_receiver.sv
rtl/time_sync_link.sv
sim/time_sync_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the time link testbench with Verilator and runs it
# the exit status is nonzero when the build fails or the testbench stops with $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   -f time_sync.f --top-module time_sync_tb -o sim_time_sync &&
./obj_dir/sim_time_sync ||
{
   echo "simulation did not complete successfully"
   exit 1
}

//--- sim/time_sync_tb.sv
/* loopback testbench for time_sync_link with inputs changing on the falling edge.
   the bit-error test runs last because the line is no longer clean after it */
`timescale 1ns/10ps
`default_nettype none

module time_sync_tb
   import time_sync_pkg::*;
();
   localparam int LOCK_COMMAS = 4;
   localparam int NUM_FRAMES  = 8;
   // about 20 frames of 100 cycles plus margin for lock and idle time
   localparam int MAX_CYCLES  = 3000;
   // send_sync to rx_time_valid takes at most about 115 cycles
   localparam int FRAME_WAIT  = 150;

   logic              clk;
   logic              rst;
   logic [TIME_W-1:0] time_in;
   logic              send_sync;
   logic              ser_out;
   logic              ser_in;
   logic [TIME_W-1:0] rx_time;
   logic              rx_time_valid;
   logic              rx_locked;
   logic              code_err;

   logic              flip_bit;
   logic              line_clean;
   integer            seed;
   int                cycle_cnt = 0;
   logic [TIME_W-1:0] exp_q[$];

   time_sync_link #(
      .LOCK_COMMAS (LOCK_COMMAS)
   ) dut0 (
      .clk           (clk),
      .rst           (rst),
      .time_in       (time_in),
      .send_sync     (send_sync),
      .ser_out       (ser_out),
      .ser_in        (ser_in),
      .rx_time       (rx_time),
      .rx_time_valid (rx_time_valid),
      .rx_locked     (rx_locked),
      .code_err      (code_err)
   );

   // flip_bit inverts the bit that the receiver samples next
   assign ser_in = ser_out ^ flip_bit;

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at cycle %0d", cycle_cnt);
   endtask

   function automatic logic [TIME_W-1:0] random_time();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $random(seed);
      lo = $random(seed);
      return {hi, lo};
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // pulses send_sync for one cycle starting at a falling edge
   task automatic send_time(input logic [TIME_W-1:0] value, input bit expect_rx);
      time_in   = value;
      send_sync = 1'b1;
      if (expect_rx)
         exp_q.push_back(value);
      @(negedge clk);
      send_sync = 1'b0;
      // the link has to keep the value captured with send_sync
      time_in   = random_time();
   endtask

   task automatic wait_received();
      int n;
      n = 0;
      while (exp_q.size() > 0 && n < FRAME_WAIT)
      begin
         @(negedge clk);
         n++;
      end
      assert (exp_q.size() == 0)
      else report_failure("no rx_time_valid arrived for a frame that was sent");
   endtask

   task automatic wait_lock(input int limit);
      int n;
      n = 0;
      while (!rx_locked && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      assert (rx_locked)
      else report_failure("rx_locked did not rise within the expected time");
   endtask

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      assert (cycle_cnt < MAX_CYCLES)
      else report_failure("timeout, the run took too many cycles");
   end

   // every rx_time_valid has to match the oldest value still expected
   always @(negedge clk)
   begin
      if (!rst && rx_time_valid)
      begin
         assert (exp_q.size() > 0)
         else report_failure("rx_time_valid pulsed with no frame outstanding");
         assert (rx_time == exp_q[0])
         else report_failure($sformatf("FAILED rx_time: got %h expected %h",
                                       rx_time, exp_q[0]));
         void'(exp_q.pop_front());
      end
   end

   a_no_code_err: assert property (@(posedge clk) disable iff (rst)
      line_clean |-> !code_err)
      else report_failure("code_err pulsed while no bit errors were injected");

   a_lock_held: assert property (@(posedge clk) disable iff (rst)
      $fell(rx_locked) |-> !line_clean)
      else report_failure("rx_locked fell while no bit errors were injected");

   initial
   begin
      int gap;
      seed       = 32'h5df0;
      rst        = 1'b1;
      time_in    = '0;
      send_sync  = 1'b0;
      flip_bit   = 1'b0;
      line_clean = 1'b1;
      repeat (2) @(negedge clk);
      rst = 1'b0;

      wait_lock(20 * LOCK_COMMAS);

      // each random value has to be received once and in order
      for (int i = 0; i < NUM_FRAMES; i++)
      begin
         send_time(random_time(), 1'b1);
         wait_received();
         idle_cycles(10);
      end

      // a second send_sync aborts the first frame, which must never show up
      gap = 30 + int'($unsigned($random(seed)) % 31);
      send_time(random_time(), 1'b0);
      idle_cycles(gap - 1);
      send_time(random_time(), 1'b1);
      wait_received();
      idle_cycles(10);

      // only idle commas on the line so no rx_time_valid may appear
      idle_cycles(500);

      // 45 cycles after send_sync the receiver samples the third or fourth time byte
      send_time(random_time(), 1'b0);
      idle_cycles(44);
      line_clean = 1'b0;
      flip_bit   = 1'b1;
      @(negedge clk);
      flip_bit = 1'b0;
      // a clean frame follows once the damaged one has passed and lock is back
      idle_cycles(90);
      wait_lock(20 * LOCK_COMMAS + 40);
      send_time(random_time(), 1'b1);
      wait_received();
      idle_cycles(10);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/time_sync_link.sv
/* sender and receiver of the time link; ser_out and ser_in are separate
   so a loopback or a board trace can join them, both ends run on clk */
`timescale 1ns/10ps
`default_nettype none

module time_sync_link
   import time_sync_pkg::*;
#(
   parameter int LOCK_COMMAS = 4
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic [TIME_W-1:0] time_in,
   input  logic              send_sync,
   output logic              ser_out,
   input  logic              ser_in,
   output logic [TIME_W-1:0] rx_time,
   output logic              rx_time_valid,
   output logic              rx_locked,
   output logic              code_err
);
   code_word_if enc_cw ();

   enc_8b10b u_enc (
      .cw (enc_cw)
   );

   time_sender u_tx (
      .clk       (clk),
      .rst       (rst),
      .time_in   (time_in),
      .send_sync (send_sync),
      .ser_out   (ser_out),
      .cw        (enc_cw)
   );

   time_receiver #(
      .LOCK_COMMAS (LOCK_COMMAS)
   ) u_rx (
      .clk           (clk),
      .rst           (rst),
      .ser_in        (ser_in),
      .rx_time       (rx_time),
      .rx_time_valid (rx_time_valid),
      .rx_locked     (rx_locked),
      .code_err      (code_err)
   );

endmodule

`default_nettype wire

//--- rtl/time_receiver.sv
/* shares clk with the sender, no oversampling; a comma at a new alignment
   drops lock and LOCK_COMMAS aligned commas are needed before frames count */
`timescale 1ns/10ps
`default_nettype none

module time_receiver
   import time_sync_pkg::*;
#(
   parameter int LOCK_COMMAS = 4
)
(
   input  logic              clk,
   input  logic              rst,
   input  logic              ser_in,
   output logic [TIME_W-1:0] rx_time,
   output logic              rx_time_valid,
   output logic              rx_locked,
   output logic              code_err
);
   localparam int CNT_W = $clog2(LOCK_COMMAS + 1);
   // K28.5 in both polarities, bit 0 received first
   localparam logic [CODE_W-1:0] COMMA_NEG = 10'b0101111100;
   localparam logic [CODE_W-1:0] COMMA_POS = 10'b1010000011;

   code_word_if dcw ();

   dec_8b10b u_dec (
      .cw (dcw)
   );

   rx_state_t         state;
   logic [CODE_W-1:0] win;
   logic [TIME_W-1:0] time_sr;
   logic [3:0]        bit_cnt;
   logic [CNT_W-1:0]  comma_cnt;
   logic [2:0]        byte_cnt;
   logic              rd;
   logic              comma_hit;
   logic              boundary;

   assign comma_hit = (win == COMMA_NEG) || (win == COMMA_POS);
   assign boundary  = (bit_cnt == 4'd9);
   assign dcw.code  = win;
   assign dcw.rd_in = rd;

   always_ff @(posedge clk)
   begin
      win <= {ser_in, win[CODE_W-1:1]};
      if (boundary && state == RX_BYTES && !dcw.k)
         time_sr <= {time_sr[TIME_W-9:0], dcw.data};
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state         <= RX_WAIT_HEAD;
         bit_cnt       <= 4'd0;
         comma_cnt     <= '0;
         byte_cnt      <= 3'd0;
         rd            <= 1'b0;
         rx_time       <= '0;
         rx_time_valid <= 1'b0;
         rx_locked     <= 1'b0;
         code_err      <= 1'b0;
      end
      else
      begin
         rx_time_valid <= 1'b0;
         code_err      <= 1'b0;
         if (comma_hit && !boundary)
         begin
            // realign to the comma just seen
            bit_cnt   <= 4'd0;
            comma_cnt <= '0;
            rx_locked <= 1'b0;
            state     <= RX_WAIT_HEAD;
            rd        <= (win == COMMA_NEG);
         end
         else if (!boundary)
         begin
            bit_cnt <= bit_cnt + 4'd1;
         end
         else
         begin
            bit_cnt <= 4'd0;
            rd      <= comma_hit ? (win == COMMA_NEG) : dcw.rd_out;
            if (dcw.err && !comma_hit)
            begin
               code_err  <= rx_locked;
               rx_locked <= 1'b0;
               comma_cnt <= '0;
               state     <= RX_WAIT_HEAD;
            end
            else
            begin
               if (comma_hit && !rx_locked)
               begin
                  if (comma_cnt == CNT_W'(LOCK_COMMAS - 1))
                     rx_locked <= 1'b1;
                  else
                     comma_cnt <= comma_cnt + 1'b1;
               end
               if (rx_locked)
               begin
                  if (dcw.k && dcw.data == K_HEAD)
                  begin
                     state    <= RX_BYTES;
                     byte_cnt <= 3'd0;
                  end
                  else if (state == RX_BYTES)
                  begin
                     if (dcw.k)
                        state <= RX_WAIT_HEAD;
                     else if (byte_cnt == 3'(TIME_BYTES - 1))
                        state <= RX_TAIL;
                     else
                        byte_cnt <= byte_cnt + 3'd1;
                  end
                  else if (state == RX_TAIL)
                  begin
                     state <= RX_WAIT_HEAD;
                     if (dcw.k && dcw.data == K_TAIL)
                     begin
                        rx_time       <= time_sr;
                        rx_time_valid <= 1'b1;
                     end
                  end
               end
            end
         end
      end
   end

   a_valid_locked: assert property (@(posedge clk) disable iff (rst)
      rx_time_valid |-> rx_locked);

endmodule

`default_nettype wire

//--- rtl/time_sender.sv
/* frames the captured time as head, eight bytes msb first and tail, commas
   otherwise; send_sync keeps character alignment so the receiver stays locked */
`timescale 1ns/10ps
`default_nettype none

module time_sender
   import time_sync_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [TIME_W-1:0] time_in,
   input  logic              send_sync,
   output logic              ser_out,
   code_word_if.enc_user     cw
);
   send_state_t       state;
   logic [TIME_W-1:0] time_reg;
   logic [3:0]        bit_cnt;
   logic [CODE_W-1:0] shift;
   logic              rd;
   logic [2:0]        byte_idx;
   logic              new_word;

   assign new_word = (bit_cnt == 4'd9);
   // T0 carries the most significant byte
   assign byte_idx = 3'(int'(S_T7) - int'(state));
   assign cw.rd_in = rd;

   always_comb
   begin
      case (state)
         S_HEAD:
         begin
            cw.k    = 1'b1;
            cw.data = K_HEAD;
         end
         S_TAIL:
         begin
            cw.k    = 1'b1;
            cw.data = K_TAIL;
         end
         S_IDLE:
         begin
            cw.k    = 1'b1;
            cw.data = K_COMMA;
         end
         default:
         begin
            cw.k    = 1'b0;
            cw.data = time_reg[byte_idx*8 +: 8];
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         bit_cnt <= 4'd0;
      else if (new_word)
         bit_cnt <= 4'd0;
      else
         bit_cnt <= bit_cnt + 4'd1;
   end

   always_ff @(posedge clk)
   begin
      if (send_sync)
         time_reg <= time_in;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= S_IDLE;
         rd      <= 1'b0;
         shift   <= '0;
         ser_out <= 1'b0;
      end
      else
      begin
         ser_out <= shift[0];
         if (new_word)
         begin
            shift <= cw.code;
            rd    <= cw.rd_out;
         end
         else
         begin
            shift <= {1'b0, shift[CODE_W-1:1]};
         end
         // a new sync aborts any frame, the head follows at the next boundary
         if (send_sync)
            state <= S_HEAD;
         else if (new_word && state == S_TAIL)
            state <= S_IDLE;
         else if (new_word && state != S_IDLE)
            state <= send_state_t'(state + 4'd1);
      end
   end

   a_bit_cnt_range: assert property (@(posedge clk) disable iff (rst)
      bit_cnt <= 4'd9);

   // every character chosen above must be one the encoder knows
   a_enc_legal: assert property (@(posedge clk) disable iff (rst)
      new_word |-> !cw.err);

endmodule

`default_nettype wire

//--- rtl/dec_8b10b.sv
/* combinational 8b10b decoder; err covers invalid sub-blocks, misplaced
   A7/P7 codes and disparity against rd_in, run-length rules are not checked */
`timescale 1ns/10ps
`default_nettype none

module dec_8b10b
   import time_sync_pkg::*;
(
   code_word_if.dec cw
);
   logic [5:0] s6;
   logic [5:0] x6;
   logic [3:0] s4;
   logic [3:0] x4;
   logic [4:0] d5;
   logic [2:0] d3;
   logic [2:0] n6;
   logic [2:0] n4;
   logic       rd1;
   logic       k28;
   logic       k_alt;
   logic       a7;
   logic       a7_ok;
   logic       found6;
   logic       found4;
   logic       disp_err;

   always_comb
   begin
      for (int i = 0; i < 6; i++)
      begin
         s6[5-i] = cw.code[i];
      end
      for (int i = 0; i < 4; i++)
      begin
         s4[3-i] = cw.code[6+i];
      end
      n6 = 3'($countones(s6));
      n4 = 3'($countones(s4));

      // bring the 6b block back to its negative-disparity form
      if (n6 == 3'd2)
         x6 = ~s6;
      else if (s6 == 6'b000111)
         x6 = 6'b111000;
      else
         x6 = s6;
      k28    = (x6 == 6'b001111);
      found6 = k28;
      d5     = k28 ? 5'd28 : 5'd0;
      for (int i = 0; i < 32; i++)
      begin
         if (enc_6b(5'(i)) == x6)
         begin
            found6 = 1'b1;
            d5     = 5'(i);
         end
      end
      rd1 = (n6 == 3'd4) ? 1'b1 : (n6 == 3'd2) ? 1'b0 : cw.rd_in;

      if (n4 == 3'd1)
         x4 = ~s4;
      else if (s4 == 4'b0011)
         x4 = 4'b1100;
      else
         x4 = s4;
      // K28 sends its balanced 4b codes inverted after a positive 6b block
      if (k28 && !rd1 && n4 == 3'd2 && x4 != 4'b1100)
         x4 = ~x4;
      a7     = (x4 == 4'b0111);
      found4 = a7;
      d3     = a7 ? 3'd7 : 3'd0;
      for (int i = 0; i < 8; i++)
      begin
         if (enc_4b(3'(i)) == x4)
         begin
            found4 = 1'b1;
            d3     = 3'(i);
         end
      end

      k_alt = a7 && (d5 inside {5'd23, 5'd27, 5'd29, 5'd30});
      a7_ok = (!rd1 && (d5 inside {5'd17, 5'd18, 5'd20})) ||
              (rd1 && (d5 inside {5'd11, 5'd13, 5'd14}));
      disp_err = (n6 == 3'd4 && cw.rd_in) || (n6 == 3'd2 && !cw.rd_in) ||
                 (s6 == 6'b111000 && cw.rd_in) || (s6 == 6'b000111 && !cw.rd_in) ||
                 (n4 == 3'd3 && rd1) || (n4 == 3'd1 && !rd1) ||
                 (s4 == 4'b1100 && rd1) || (s4 == 4'b0011 && !rd1);

      cw.k      = k28 || k_alt;
      cw.data   = {d3, d5};
      cw.rd_out = (n4 == 3'd3) ? 1'b1 : (n4 == 3'd1) ? 1'b0 : rd1;
      cw.err    = !found6 || !found4 || disp_err ||
                  (a7 && !k28 && !k_alt && !a7_ok) ||
                  (!a7 && d3 == 3'd7 && (a7_ok || k28));
   end

endmodule

`default_nettype wire

//--- rtl/enc_8b10b.sv
/* combinational 8b10b encoder; code bit 0 is the a bit and goes out first.
   err flags a control character outside K28.x, K23.7, K27.7, K29.7, K30.7 */
`timescale 1ns/10ps
`default_nettype none

module enc_8b10b
   import time_sync_pkg::*;
(
   code_word_if.enc cw
);
   logic [5:0]        r6;
   logic [5:0]        s6;
   logic [3:0]        r4;
   logic [3:0]        s4;
   logic [CODE_W-1:0] code_v;
   logic              is_k28;
   logic              bal6;
   logic              bal4;
   logic              rd1;
   logic              use_a7;

   always_comb
   begin
      is_k28 = cw.k && (cw.data[4:0] == 5'd28);
      r6     = is_k28 ? 6'b001111 : enc_6b(cw.data[4:0]);
      bal6   = ($countones(r6) == 3);
      // disparity between the two sub-blocks
      rd1    = bal6 ? cw.rd_in : ~cw.rd_in;
      if (r6 == 6'b111000 && cw.rd_in)
         s6 = 6'b000111;
      else if (!bal6 && cw.rd_in)
         s6 = ~r6;
      else
         s6 = r6;

      // A7 avoids a run of five equal bits across the sub-block border
      use_a7 = (cw.data[7:5] == 3'd7) &&
               (cw.k ||
                (!rd1 && (cw.data[4:0] inside {5'd17, 5'd18, 5'd20})) ||
                (rd1 && (cw.data[4:0] inside {5'd11, 5'd13, 5'd14})));
      r4   = use_a7 ? 4'b0111 : enc_4b(cw.data[7:5]);
      bal4 = ($countones(r4) == 2);
      if (r4 == 4'b1100 && rd1)
         s4 = 4'b0011;
      else if (!bal4 && rd1)
         s4 = ~r4;
      else if (is_k28 && bal4 && !rd1 && r4 != 4'b1100)
         s4 = ~r4;
      else
         s4 = r4;

      for (int i = 0; i < 6; i++)
      begin
         code_v[i] = s6[5-i];
      end
      for (int i = 0; i < 4; i++)
      begin
         code_v[6+i] = s4[3-i];
      end
      cw.code   = code_v;
      cw.rd_out = bal4 ? rd1 : ~rd1;
      cw.err    = cw.k && !(is_k28 || ((cw.data[7:5] == 3'd7) &&
                  (cw.data[4:0] inside {5'd23, 5'd27, 5'd29, 5'd30})));
   end

endmodule

`default_nettype wire

//--- rtl/code_word_if.sv
/* one 8b10b character with its running disparity; no handshake, the codec
   is combinational and the user registers rd_out on character boundaries */
`timescale 1ns/10ps
`default_nettype none

interface code_word_if
   import time_sync_pkg::*;
();
   logic [7:0]        data;
   logic              k;
   logic [CODE_W-1:0] code;
   logic              rd_in;
   logic              rd_out;
   // encoder: illegal control character, decoder: code or disparity error
   logic              err;

   modport enc      (input data, k, rd_in, output code, rd_out, err);
   modport enc_user (output data, k, rd_in, input code, rd_out, err);
   modport dec      (input code, rd_in, output data, k, rd_out, err);
   modport dec_user (output code, rd_in, input data, k, rd_out, err);

endinterface

`default_nettype wire

//--- rtl/time_sync_pkg.sv
/* shared widths, control characters and state types for the time link.
   enc_6b and enc_4b return the negative-disparity form, a-bit in the msb */
`default_nettype none

package time_sync_pkg;

   localparam int TIME_W     = 64;
   localparam int TIME_BYTES = 8;
   localparam int CODE_W     = 10;

   // control characters, given as the data byte sent with k set
   localparam logic [7:0] K_COMMA = 8'hBC;
   localparam logic [7:0] K_HEAD  = 8'h3C;
   localparam logic [7:0] K_TAIL  = 8'hF7;

   typedef enum logic [3:0] {
      S_IDLE,
      S_HEAD,
      S_T0,
      S_T1,
      S_T2,
      S_T3,
      S_T4,
      S_T5,
      S_T6,
      S_T7,
      S_TAIL
   } send_state_t;

   typedef enum logic [1:0] {
      RX_WAIT_HEAD,
      RX_BYTES,
      RX_TAIL
   } rx_state_t;

   // 5b6b data table, abcdei from left to right
   function automatic logic [5:0] enc_6b(input logic [4:0] v);
      case (v)
         5'd0:    return 6'b100111;
         5'd1:    return 6'b011101;
         5'd2:    return 6'b101101;
         5'd3:    return 6'b110001;
         5'd4:    return 6'b110101;
         5'd5:    return 6'b101001;
         5'd6:    return 6'b011001;
         5'd7:    return 6'b111000;
         5'd8:    return 6'b111001;
         5'd9:    return 6'b100101;
         5'd10:   return 6'b010101;
         5'd11:   return 6'b110100;
         5'd12:   return 6'b001101;
         5'd13:   return 6'b101100;
         5'd14:   return 6'b011100;
         5'd15:   return 6'b010111;
         5'd16:   return 6'b011011;
         5'd17:   return 6'b100011;
         5'd18:   return 6'b010011;
         5'd19:   return 6'b110010;
         5'd20:   return 6'b001011;
         5'd21:   return 6'b101010;
         5'd22:   return 6'b011010;
         5'd23:   return 6'b111010;
         5'd24:   return 6'b110011;
         5'd25:   return 6'b100110;
         5'd26:   return 6'b010110;
         5'd27:   return 6'b110110;
         5'd28:   return 6'b001110;
         5'd29:   return 6'b101110;
         5'd30:   return 6'b011110;
         default: return 6'b101011;
      endcase
   endfunction

   // 3b4b data table, fghj from left to right, x.7 as the primary code
   function automatic logic [3:0] enc_4b(input logic [2:0] v);
      case (v)
         3'd0:    return 4'b1011;
         3'd1:    return 4'b1001;
         3'd2:    return 4'b0101;
         3'd3:    return 4'b1100;
         3'd4:    return 4'b1101;
         3'd5:    return 4'b1010;
         3'd6:    return 4'b0110;
         default: return 4'b1110;
      endcase
   endfunction

endpackage

`default_nettype wire
